//--- sim.f
+incdir+src
src/dma_bench_pkg.sv
src/dma_bench_replay.sv
src/dma_bench_fifo.sv
src/dma_bench_release.sv
src/dma_bench.sv
tests/dma_bench_chk.sv
tests/tb_dma_bench.sv

//--- Bender.yml
package:
  name: dma_bench

export_include_dirs:
  - src

sources:
  - files:
      - src/dma_bench_pkg.sv
      - src/dma_bench_replay.sv
      - src/dma_bench_fifo.sv
      - src/dma_bench_release.sv
      - src/dma_bench.sv
  - target: test
    files:
      - tests/dma_bench_chk.sv
      - tests/tb_dma_bench.sv

//--- tests/tb_dma_bench.sv
// testbench for the dma benchmarking shim
// directed runs for threshold hold, descriptor replay, flush, stall and latency
`timescale 1ns/1ns
`include "dma_bench_cfg.svh"

module tb_dma_bench
	import dma_bench_pkg::*;
();

	localparam int WAIT_LIMIT = 300; // cycles any single wait may take

	logic                        CLK = 1'b0;
	logic                        RST_N;
	dma_desc_t                   desc;
	logic                        engine_valid;
	dma_desc_t                   engine_desc;
	logic                        engine_go;
	logic                        end_of_op;
	rq_beat_t                    rq_in;
	logic                        rq_in_valid;
	logic                        rq_in_ready;
	rq_beat_t                    rq_out;
	logic                        rq_out_valid;
	logic                        rq_out_ready;
	logic                        done;
	logic [`DMA_BENCH_LAT_W-1:0] latency;

	logic [31:0] rng = 32'h34cf_c6d1; // xorshift state
	rq_beat_t    in_q[$];             // beats waiting to enter
	rq_beat_t    exp_q[$];            // beats held by the dut, oldest first
	int          cyc;                 // falling edges seen
	int          first_hs;            // cycle of the first release
	int          last_hs;             // cycle of the latest release
	bit          seen_first;

	dma_bench dma_bench_i (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.desc         (desc),
		.engine_valid (engine_valid),
		.engine_desc  (engine_desc),
		.engine_go    (engine_go),
		.end_of_op    (end_of_op),
		.rq_in        (rq_in),
		.rq_in_valid  (rq_in_valid),
		.rq_in_ready  (rq_in_ready),
		.rq_out       (rq_out),
		.rq_out_valid (rq_out_valid),
		.rq_out_ready (rq_out_ready),
		.done         (done),
		.latency      (latency)
	);

	always #10 CLK = ~CLK; // 20 ns period

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic rq_beat_t make_beat();
		rq_beat_t    b;
		logic [31:0] r;
		for (int i = 0; i < `DMA_BENCH_DATA_W / 32; i++) begin
			b.data[i*32 +: 32] = next_rand();
		end
		r      = next_rand();
		b.keep = r[`DMA_BENCH_KEEP_W-1:0];
		b.last = r[31];
		return b;
	endfunction

	function automatic dma_desc_t make_desc();
		dma_desc_t d;
		d.addr = {next_rand(), next_rand()};
		d.size = {next_rand(), next_rand()}; // wraps mod 2^64 like the dut
		return d;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [319:0] expected,
			input logic [319:0] actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("mismatch at %0t ns: %s expected %0h got %0h",
				$time, name, expected, actual));
		end
	endtask

	// one clock cycle with outputs read at the falling edge and inputs set for the next rise
	task automatic step(input logic ready, input logic eop);
		@(negedge CLK);
		cyc++;
		rq_out_ready = ready;
		end_of_op    = eop;
		if (rq_out_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_error("a beat came out that was never sent");
			end else begin
				check("rq_out", exp_q[0], rq_out); // also holds under stall
				if (ready) begin // leaves at the coming edge
					void'(exp_q.pop_front());
					if (!seen_first) first_hs = cyc;
					seen_first = 1'b1;
					last_hs    = cyc;
				end
			end
		end
		rq_in_valid = (in_q.size() > 0);
		if (in_q.size() > 0) begin
			rq_in = in_q[0];
			if (rq_in_ready) begin
				exp_q.push_back(in_q.pop_front()); // taken at the coming edge
			end
		end
	endtask

	task automatic load_beats(input int n);
		int t;
		for (int i = 0; i < n; i++) begin
			in_q.push_back(make_beat());
		end
		t = 0;
		while (in_q.size() > 0 && t < WAIT_LIMIT) begin
			step(1'b1, 1'b0);
			t++;
		end
		if (in_q.size() > 0) stop_with_error("fifo did not accept the input beats");
	endtask

	task automatic drain_out();
		int t;
		t = 0;
		while (exp_q.size() > 0 && t < WAIT_LIMIT) begin
			step(1'b1, 1'b0);
			t++;
		end
		if (exp_q.size() > 0) stop_with_error("buffered beats never came out");
	endtask

	task automatic start_run(input dma_desc_t d);
		desc         = d;
		engine_valid = 1'b1;
		seen_first   = 1'b0;
		step(1'b1, 1'b0); // descriptor captured at this edge
		engine_valid = 1'b0;
		check("engine_go", 1, engine_go);
		check("engine_desc", d, engine_desc);
	endtask

	task automatic test_reset();
		check("engine_go", 0, engine_go);
		check("done", 0, done);
		check("rq_out_valid", 0, rq_out_valid);
		check("latency", 0, latency);
		check("rq_in_ready", 1, rq_in_ready);
	endtask

	// one beat short of the threshold nothing may leave
	task automatic test_threshold();
		load_beats(`DMA_BENCH_THRESHOLD - 1);
		for (int i = 0; i < 20; i++) begin
			step(1'b1, 1'b0);
			check("rq_out_valid", 0, rq_out_valid);
		end
		load_beats(1);
		drain_out();
	endtask

	task automatic test_replay(input dma_desc_t d);
		logic [`DMA_BENCH_ADDR_W-1:0] exp_addr;
		for (int i = 1; i <= `DMA_BENCH_ITERATIONS; i++) begin
			step(1'b1, 1'b1); // end_of_op pulse
			step(1'b1, 1'b0);
			if (`DMA_BENCH_MODE == 2) exp_addr = d.addr + d.size * 64'(i);
			else exp_addr = d.addr;
			check("engine_desc.addr", exp_addr, engine_desc.addr);
			check("engine_desc.size", d.size, engine_desc.size);
			check("engine_go", (i < `DMA_BENCH_ITERATIONS), engine_go);
		end
	endtask

	task automatic test_flush();
		int t;
		int lat_exp;
		t = 0;
		while (!done && t < WAIT_LIMIT) begin
			step(1'b1, 1'b0);
			t++;
		end
		if (!done) stop_with_error("no done pulse after the last iteration");
		lat_exp = last_hs - first_hs + 1; // first to last release inclusive
		check("beats left", 0, exp_q.size());
		check("engine_go", 0, engine_go);
		check("latency", lat_exp, latency);
		for (int i = 0; i < 5; i++) begin
			step(1'b1, 1'b0);
			check("done", 0, done); // single pulse only
			check("latency", lat_exp, latency);
		end
	endtask

	// stall the output, fill the fifo to the brim, then let it all go
	task automatic test_backpressure();
		int t;
		for (int i = 0; i < `DMA_BENCH_FIFO_DEPTH; i++) begin
			in_q.push_back(make_beat());
		end
		t = 0;
		while (in_q.size() > 0 && t < WAIT_LIMIT) begin
			step(1'b0, 1'b0); // head checked against the oldest beat
			t++;
		end
		if (in_q.size() > 0) stop_with_error("fifo stopped accepting before it was full");
		in_q.push_back(make_beat()); // one beat too many
		for (int i = 0; i < 3; i++) begin
			step(1'b0, 1'b0);
			check("rq_in_ready", 0, rq_in_ready);
			check("rq_out_valid", 1, rq_out_valid);
			check("offered beat pending", 1, in_q.size());
		end
		in_q.delete(); // withdraw it
		drain_out();
	endtask

	initial begin
		dma_desc_t d;
		RST_N        = 1'b0;
		desc         = '0;
		engine_valid = 1'b0;
		end_of_op    = 1'b0;
		rq_in        = '0;
		rq_in_valid  = 1'b0;
		rq_out_ready = 1'b0;
		cyc          = 0;
		first_hs     = 0;
		last_hs      = 0;
		seen_first   = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		test_reset();

		d = make_desc(); // run 1 with a burst and then flushed leftovers
		start_run(d);
		test_threshold();
		load_beats(5);
		test_replay(d);
		test_flush();

		d = make_desc(); // run 2 stalled and full
		start_run(d);
		test_backpressure();
		test_replay(d);
		test_flush();

		if (dma_bench_i.chk_i.fails == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

//--- tests/dma_bench_chk.sv
// dma bench protocol checker
// bound into the top level, watches the done pulse, the request output
// stream under stall and the engine enable around completion
`timescale 1ns/1ns

module dma_bench_chk
	import dma_bench_pkg::*;
(
	input logic     CLK,
	input logic     RST_N,
	input logic     done,
	input logic     engine_go,
	input logic     rq_out_valid,
	input logic     rq_out_ready,
	input rq_beat_t rq_out
);

	int unsigned fails = 0; // failed assertions so far

	// completion is a single cycle pulse
	done_one_cycle: assert property (@(posedge CLK) disable iff (!RST_N)
		done |=> !done)
		else begin
			$error("done stayed high for a second cycle");
			fails++;
		end

	// stalled beat must hold until taken
	out_stable: assert property (@(posedge CLK) disable iff (!RST_N)
		(rq_out_valid && !rq_out_ready) |=> $stable(rq_out))
		else begin
			$error("rq_out changed while stalled");
			fails++;
		end

	// engine is already stopped when the run completes
	go_low_at_done: assert property (@(posedge CLK) disable iff (!RST_N)
		done |-> !engine_go)
		else begin
			$error("engine_go high during done");
			fails++;
		end

endmodule

bind dma_bench dma_bench_chk chk_i (
	.CLK          (CLK),
	.RST_N        (RST_N),
	.done         (done),
	.engine_go    (engine_go),
	.rq_out_valid (rq_out_valid),
	.rq_out_ready (rq_out_ready),
	.rq_out       (rq_out)
);

//--- src/dma_bench.sv
// dma benchmarking shim top
// replays one descriptor to the dma engine and buffers its request beats,
// releasing them in bursts and reporting the measured latency at the end
`timescale 1ns/1ns
`include "dma_bench_cfg.svh"

module dma_bench
	import dma_bench_pkg::*;
(
	input  logic                        CLK,
	input  logic                        RST_N,
	input  dma_desc_t                   desc,         // host descriptor
	input  logic                        engine_valid, // host run request
	output dma_desc_t                   engine_desc,  // replayed descriptor
	output logic                        engine_go,
	input  logic                        end_of_op,    // engine transfer done
	input  rq_beat_t                    rq_in,        // requests from the engine
	input  logic                        rq_in_valid,
	output logic                        rq_in_ready,
	output rq_beat_t                    rq_out,       // requests to the endpoint
	output logic                        rq_out_valid,
	input  logic                        rq_out_ready,
	output logic                        done,         // run complete pulse
	output logic [`DMA_BENCH_LAT_W-1:0] latency
);

	logic                        busy;  // replay to release
	logic                        drain;
	logic                        idle;  // release to replay
	rq_beat_t                    head;  // fifo to release
	logic                        empty;
	logic [`DMA_BENCH_CNT_W-1:0] count;
	logic                        pop;   // release to fifo

	dma_bench_replay replay_i (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.desc         (desc),
		.engine_valid (engine_valid),
		.end_of_op    (end_of_op),
		.idle         (idle),
		.engine_desc  (engine_desc),
		.engine_go    (engine_go),
		.busy         (busy),
		.drain        (drain),
		.done         (done)
	);

	dma_bench_fifo fifo_i (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.wr_beat  (rq_in),
		.wr_valid (rq_in_valid),
		.wr_ready (rq_in_ready),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.count    (count)
	);

	dma_bench_release release_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.head      (head),
		.empty     (empty),
		.count     (count),
		.busy      (busy),
		.drain     (drain),
		.out_ready (rq_out_ready),
		.out_beat  (rq_out),
		.out_valid (rq_out_valid),
		.pop       (pop),
		.idle      (idle),
		.latency   (latency)
	);

endmodule

//--- src/dma_bench_release.sv
// dma bench release gate
// holds request beats until the fifo reaches the threshold or the run drains,
// then lets them out in a burst and measures first to last beat latency
`timescale 1ns/1ns
`include "dma_bench_cfg.svh"

module dma_bench_release
	import dma_bench_pkg::*;
(
	input  logic                        CLK,
	input  logic                        RST_N,
	input  rq_beat_t                    head,      // fifo head beat
	input  logic                        empty,
	input  logic [`DMA_BENCH_CNT_W-1:0] count,     // fifo occupancy
	input  logic                        busy,      // run in progress
	input  logic                        drain,     // flush remaining beats
	input  logic                        out_ready, // downstream ready
	output rq_beat_t                    out_beat,
	output logic                        out_valid,
	output logic                        pop,       // head taken downstream
	output logic                        idle,      // gate closed, fifo empty
	output logic [`DMA_BENCH_LAT_W-1:0] latency    // cycles first to last beat
);

	localparam int LAT_W = `DMA_BENCH_LAT_W;

	logic             gate_r;     // release window open
	logic             counting_r; // first beat of the run already sent
	logic [LAT_W-1:0] cnt_r;      // cycles since the first beat
	logic [LAT_W-1:0] latency_r;
	logic             fill_hit;
	logic             hs;

	assign fill_hit  = (count >= `DMA_BENCH_THRESHOLD) || (drain && !empty);
	assign out_valid = gate_r && !empty;
	assign hs        = out_valid && out_ready; // beat leaves this cycle
	assign pop       = hs;
	assign out_beat  = head; // stable while not popped
	assign idle      = !gate_r && empty;

	// gate opens on threshold or flush, closes once the fifo ran dry
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			gate_r <= 1'b0;
		end else if (gate_r) begin
			if (empty) gate_r <= 1'b0;
		end else if (fill_hit) begin
			gate_r <= 1'b1;
		end
	end

	// latency counter, armed by the first beat of a run
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			counting_r <= 1'b0;
			cnt_r      <= '0;
		end else if (!busy) begin
			counting_r <= 1'b0; // cleared between runs
			cnt_r      <= '0;
		end else if (counting_r || hs) begin
			counting_r <= 1'b1;
			cnt_r      <= cnt_r + 1'b1; // every cycle once started
		end
	end

	// each beat stores the span so far, the last one of the run stays
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			latency_r <= '0;
		end else if (hs && busy) begin
			latency_r <= cnt_r + 1'b1; // includes this cycle
		end
	end

	assign latency = latency_r;

endmodule

//--- src/dma_bench_fifo.sv
// dma bench request fifo
// synchronous circular buffer of request beats with an occupancy count
`timescale 1ns/1ns
`include "dma_bench_cfg.svh"

module dma_bench_fifo
	import dma_bench_pkg::*;
(
	input  logic                        CLK,
	input  logic                        RST_N,
	input  rq_beat_t                    wr_beat,  // beat from the engine
	input  logic                        wr_valid,
	output logic                        wr_ready, // low only when full
	input  logic                        pop,      // drop the head beat
	output rq_beat_t                    head,     // oldest beat held
	output logic                        empty,
	output logic [`DMA_BENCH_CNT_W-1:0] count     // beats held
);

	localparam int PTR_W = `DMA_BENCH_PTR_W;
	localparam int CNT_W = `DMA_BENCH_CNT_W;

	rq_beat_t           mem [`DMA_BENCH_FIFO_DEPTH]; // beat storage
	logic [PTR_W-1:0]   wr_ptr_r;
	logic [PTR_W-1:0]   rd_ptr_r;
	logic [CNT_W-1:0]   count_r;
	logic               push;
	logic               take;

	assign wr_ready = (count_r != CNT_W'(`DMA_BENCH_FIFO_DEPTH));
	assign empty    = (count_r == '0);
	assign push     = wr_valid && wr_ready;
	assign take     = pop && !empty; // never read past the tail

	// storage, written beat shows at head from the next cycle
	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr_r] <= wr_beat;
		end
	end

	// pointers and occupancy
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			if (push) begin
				// wrap at depth, not only at a power of two
				if (wr_ptr_r == PTR_W'(`DMA_BENCH_FIFO_DEPTH - 1)) wr_ptr_r <= '0;
				else wr_ptr_r <= wr_ptr_r + 1'b1;
			end
			if (take) begin
				if (rd_ptr_r == PTR_W'(`DMA_BENCH_FIFO_DEPTH - 1)) rd_ptr_r <= '0;
				else rd_ptr_r <= rd_ptr_r + 1'b1;
			end
			case ({push, take})
				2'b10:   count_r <= count_r + 1'b1;
				2'b01:   count_r <= count_r - 1'b1;
				default: count_r <= count_r; // idle or push with pop
			endcase
		end
	end

	assign head  = mem[rd_ptr_r];
	assign count = count_r;

endmodule

//--- src/dma_bench_replay.sv
// dma bench replay sequencer
// takes one descriptor from the host and replays it to the engine a fixed
// number of times, then waits for the request fifo to drain and pulses done
`timescale 1ns/1ns
`include "dma_bench_cfg.svh"

module dma_bench_replay
	import dma_bench_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	input  dma_desc_t desc,         // descriptor from the host
	input  logic      engine_valid, // host starts a run
	input  logic      end_of_op,    // engine finished one transfer
	input  logic      idle,         // release gate closed and fifo empty
	output dma_desc_t engine_desc,  // descriptor replayed to the engine
	output logic      engine_go,    // engine enable
	output logic      busy,         // run in progress
	output logic      drain,        // flush phase after the last iteration
	output logic      done          // one cycle completion pulse
);

	localparam int ITER_W = $clog2(`DMA_BENCH_ITERATIONS + 1);

	typedef enum logic [1:0] {
		st_idle,  // waiting for the host
		st_run,   // engine replaying the descriptor
		st_drain  // flushing what is left in the fifo
	} state_t;

	state_t            state_r;
	logic [ITER_W-1:0] iter_r;  // finished iterations
	dma_desc_t         base_r;  // descriptor as captured from the host
	dma_desc_t         cur_r;   // descriptor of the current iteration
	logic              done_r;
	logic              start;
	logic              last_op;

	assign start   = (state_r == st_idle) && engine_valid;
	assign last_op = end_of_op && (iter_r == ITER_W'(`DMA_BENCH_ITERATIONS - 1)); // final pulse

	// sequencer
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			state_r <= st_idle;
			iter_r  <= '0;
			done_r  <= 1'b0;
		end else begin
			done_r <= 1'b0; // pulse by default low
			case (state_r)
				st_idle: begin
					if (engine_valid) begin
						state_r <= st_run;
						iter_r  <= '0; // fresh count per run
					end
				end
				st_run: begin
					if (end_of_op) begin
						iter_r <= iter_r + 1'b1;
						if (last_op) begin
							state_r <= st_drain; // engine_go falls here
						end
					end
				end
				st_drain: begin
					if (idle) begin // everything released downstream
						done_r  <= 1'b1;
						state_r <= st_idle;
					end
				end
				default: begin
					state_r <= st_idle;
				end
			endcase
		end
	end

	// descriptor registers, payload only
	always_ff @(posedge CLK) begin
		if (start) begin
			base_r <= desc;
			cur_r  <= desc;
		end else if ((state_r == st_run) && end_of_op) begin
			if (`DMA_BENCH_MODE == 2) begin
				cur_r.addr <= cur_r.addr + cur_r.size; // step to the next region
			end else begin
				cur_r.addr <= base_r.addr; // same region every time
			end
			cur_r.size <= base_r.size;
		end
	end

	assign engine_desc = cur_r;
	assign engine_go   = (state_r == st_run);
	assign busy        = (state_r != st_idle); // low again in the done cycle
	assign drain       = (state_r == st_drain);
	assign done        = done_r;

endmodule

//--- src/dma_bench_pkg.sv
// shared types of the dma benchmarking shim
// request stream beat and host descriptor
`include "dma_bench_cfg.svh"

package dma_bench_pkg;

	// one beat of the requester request stream
	typedef struct packed {
		logic [`DMA_BENCH_DATA_W-1:0] data; // payload word
		logic [`DMA_BENCH_KEEP_W-1:0] keep; // valid dwords
		logic                         last; // end of tlp
	} rq_beat_t;

	// descriptor handed to the engine
	typedef struct packed {
		logic [`DMA_BENCH_ADDR_W-1:0] addr; // host address of the transfer
		logic [`DMA_BENCH_ADDR_W-1:0] size; // bytes per transfer
	} dma_desc_t;

endpackage

//--- src/dma_bench_cfg.svh
// dma benchmarking shim configuration
// request beat geometry, fifo sizing, replay count and address mode
`ifndef DMA_BENCH_CFG_SVH
`define DMA_BENCH_CFG_SVH

`define DMA_BENCH_DATA_W      256 // request data word
`define DMA_BENCH_KEEP_W      8   // one keep bit per dword
`define DMA_BENCH_ADDR_W      64  // descriptor address and size

`define DMA_BENCH_FIFO_DEPTH  64  // beats held before release
`define DMA_BENCH_THRESHOLD   16  // occupancy that opens the release gate

`define DMA_BENCH_ITERATIONS  4   // descriptor replays per run
`define DMA_BENCH_MODE        2   // 1 same address, 2 next region each time

// derived widths
`define DMA_BENCH_PTR_W  $clog2(`DMA_BENCH_FIFO_DEPTH)     // fifo pointer
`define DMA_BENCH_CNT_W  $clog2(`DMA_BENCH_FIFO_DEPTH + 1) // fifo occupancy, 0..depth
`define DMA_BENCH_LAT_W  32                                // latency counter

`endif
